// File: Makefile
# Verilator build and run of the colour mixer testbench
TOP := tb_colmix

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f src.f -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: colmix_macros.svh
`ifndef COLMIX_MACROS_SVH
`define COLMIX_MACROS_SVH

// palette word address, 4096 entries
`define PAL_AW 12

// palette word, three 5-bit channels plus the brighten bit
`define PAL_DW 16

// one colour channel
`define CH_W 5

// blank flag delay in pixel strobes, ahead of the output register
`define BLANK_DLY 2

`endif

// File: colmix_top.sv
`timescale 1ns/1ps
`include "colmix_macros.svh"

module colmix_top
    import video_pkg::*;
    import cpu_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         pxl_cen,
    input  layer_pixel_t layer,
    input  blank_t       pre_blank,
    input  cpu_wr_t      cpu,
    output cpu_word_t    cpu_din,
    output rgb_t         rgb,
    output blank_t       blank
);

    logic [`PAL_AW-1:0] pal_addr;
    logic [`PAL_DW-1:0] pal_word;
    shade_ctrl_t        shade_ctrl;
    shade_ctrl_t        shade_dly;
    // 0 red, 1 green, 2 blue
    logic [`CH_W-1:0]   pal_chan [3];
    logic [`CH_W-1:0]   shaded   [3];
    logic               bright;

    // layer select and palette address, strobe N
    layer_priority layer_priority_i (
        .clk        (clk),
        .reset      (reset),
        .pxl_cen    (pxl_cen),
        .layer      (layer),
        .pal_addr   (pal_addr),
        .shade_ctrl (shade_ctrl)
    );

    palette_ram palette_ram_i (
        .clk      (clk),
        .pxl_cen  (pxl_cen),
        .cpu      (cpu),
        .cpu_din  (cpu_din),
        .pal_addr (pal_addr),
        .pal_word (pal_word)
    );

    // shadow follows the address into the shade stage
    pixel_delay #(
        .payload_t (shade_ctrl_t),
        .DEPTH     (1)
    ) shade_dly_i (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .din     (shade_ctrl),
        .dout    (shade_dly)
    );

    // top bit of the palette word selects brighten over dim
    assign bright = pal_word[15];

    // per channel: four high bits in a nibble, lsb from bits 12-14
    for (genvar i = 0; i < 3; i++) begin : g_chan
        assign pal_chan[i] = {pal_word[4*i +: 4], pal_word[12+i]};

        // strobe N+1
        shade_unit shade_unit_i (
            .clk      (clk),
            .reset    (reset),
            .pxl_cen  (pxl_cen),
            .chan_in  (pal_chan[i]),
            .bright   (bright),
            .shadow   (shade_dly.shadow),
            .chan_out (shaded[i])
        );
    end

    // strobe N+2
    video_output video_output_i (
        .clk       (clk),
        .reset     (reset),
        .pxl_cen   (pxl_cen),
        .chan_r    (shaded[0]),
        .chan_g    (shaded[1]),
        .chan_b    (shaded[2]),
        .pre_blank (pre_blank),
        .rgb       (rgb),
        .blank     (blank)
    );

endmodule

// File: cpu_pkg.sv
`include "colmix_macros.svh"

package cpu_pkg;

    // one palette access from the main CPU
    typedef struct packed {
        // chip select, a write happens every clock it is high
        logic              cs;
        // word address
        logic [`PAL_AW-1:0] addr;
        logic [`PAL_DW-1:0] data;
        // byte strobes, active low, bit 1 is the upper byte
        logic [1:0]        dswn;
    } cpu_wr_t;

    // read-back word
    typedef logic [`PAL_DW-1:0] cpu_word_t;

endpackage

// File: layer_priority.sv
`timescale 1ns/1ps
`include "colmix_macros.svh"

module layer_priority
    import video_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               pxl_cen,
    input  layer_pixel_t       layer,
    output logic [`PAL_AW-1:0] pal_addr,
    output shade_ctrl_t        shade_ctrl
);

    // object pixel from the previous strobe
    logic [13:0]        obj_l;
    logic               road_sel;
    logic               obj_clear;
    logic               obj_special;
    logic               road_open;
    logic [`PAL_AW-1:0] next_addr;

    // held object pixel, priority looks one pixel back
    always_ff @(posedge clk) begin
        if (reset) begin
            obj_l <= '0;
        end else if (pxl_cen) begin
            obj_l <= layer.obj;
        end
    end

    always_comb begin
        // transparent object, or shadow shows the road through
        obj_clear   = (obj_l[3:0] == 4'h0) || layer.shadow;
        // rc3 low or no tile priority
        road_open   = !layer.rc[3] || (!layer.sa && !layer.sb);
        // one object colour/priority code lets the road win
        obj_special = (obj_l[11:10] == 2'b10) && (obj_l[3:0] == 4'b0101);
        road_sel    = !layer.fix && ((obj_clear && road_open) || obj_special);

        if (road_sel) begin
            // road colours live in the 0x400 bank
            next_addr = {2'b01, {3{layer.road[7]}}, layer.road[6:0]};
        end else if (layer.sa || layer.sb || layer.fix) begin
            // tile map, lower half
            next_addr = {1'b0, layer.tile_addr};
        end else begin
            // object, shadow and priority bits 6:4 dropped
            next_addr = {1'b1, layer.obj[13:7], layer.obj[3:0]};
        end
    end

    // address for the palette
    always_ff @(posedge clk) begin
        if (reset) begin
            pal_addr <= '0;
        end else if (pxl_cen) begin
            pal_addr <= next_addr;
        end
    end

    // shadow of the pixel whose address loads this strobe,
    // the shade delay registers it next to pal_addr
    assign shade_ctrl.shadow = layer.shadow;

endmodule

// File: palette_ram.sv
`timescale 1ns/1ps
`include "colmix_macros.svh"

module palette_ram
    import cpu_pkg::*;
(
    input  logic               clk,
    input  logic               pxl_cen,
    input  cpu_wr_t            cpu,
    output cpu_word_t          cpu_din,
    input  logic [`PAL_AW-1:0] pal_addr,
    output logic [`PAL_DW-1:0] pal_word
);

    localparam int DEPTH = 1 << `PAL_AW;

    // palette storage, no reset
    logic [`PAL_DW-1:0] mem [0:DEPTH-1];

    // cpu port
    // byte lanes written under their own strobe
    always_ff @(posedge clk) begin
        if (cpu.cs) begin
            for (int k = 0; k < 2; k++) begin
                if (!cpu.dswn[k]) begin
                    mem[cpu.addr][8*k +: 8] <= cpu.data[8*k +: 8];
                end
            end
        end
    end

    // read-back, old data on a same-clock write
    always_ff @(posedge clk) begin
        cpu_din <= mem[cpu.addr];
    end

    // video port
    // read every clock, one clock latency
    always_ff @(posedge clk) begin
        pal_word <= mem[pal_addr];
    end

    // the video word settles one clock after the address,
    // so two strobes in a row would sample a stale word
    assert property (@(posedge clk) pxl_cen |=> !pxl_cen)
        else $error("palette_ram: pxl_cen high in consecutive clocks");

endmodule

// File: pixel_delay.sv
`timescale 1ns/1ps

module pixel_delay #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     pxl_cen,
    input  payload_t din,
    output payload_t dout
);

    // shift stages, stage 0 nearest the input
    payload_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else if (pxl_cen) begin
            stage[0] <= din;
            // move one place per pixel
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    // oldest entry
    assign dout = stage[DEPTH-1];

endmodule

// File: shade_unit.sv
`timescale 1ns/1ps
`include "colmix_macros.svh"

module shade_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             pxl_cen,
    input  logic [`CH_W-1:0] chan_in,
    input  logic             bright,
    input  logic             shadow,
    output logic [`CH_W-1:0] chan_out
);

    // one extra bit for the carry of the brighten sum
    logic [`CH_W:0]   lit_sum;
    logic [`CH_W-1:0] lit;
    logic [`CH_W-1:0] dim;
    logic [`CH_W-1:0] shaded;

    always_comb begin
        // x + x/4
        lit_sum = {1'b0, chan_in} + {1'b0, chan_in >> 2};
        // clamp at full scale
        lit     = lit_sum[`CH_W] ? {`CH_W{1'b1}} : lit_sum[`CH_W-1:0];
        // x - x/4, cannot underflow
        dim     = chan_in - (chan_in >> 2);

        if (!shadow) begin
            shaded = chan_in;
        end else if (bright) begin
            shaded = lit;
        end else begin
            shaded = dim;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            chan_out <= '0;
        end else if (pxl_cen) begin
            chan_out <= shaded;
        end
    end

    // brightening never darkens, saturation included
    assert property (@(posedge clk) disable iff (reset)
        (pxl_cen && shadow && bright) |=> (chan_out >= $past(chan_in)))
        else $error("shade_unit: brightened channel below its input");

endmodule

// File: src.f
+incdir+.
video_pkg.sv
cpu_pkg.sv
pixel_delay.sv
palette_ram.sv
layer_priority.sv
shade_unit.sv
video_output.sv
colmix_top.sv
tb_colmix.sv

// File: tb_colmix.sv
`timescale 1ns/1ps
`include "colmix_macros.svh"

module tb_colmix
    import video_pkg::*;
    import cpu_pkg::*;
();

    // clocks allowed for one pixel strobe to show up
    localparam int STROBE_TIMEOUT = 16;

    // predicted output of one pixel tagged with its strobe
    typedef struct packed {
        logic [31:0] strobe;
        rgb_t        rgb;
        blank_t      blank;
    } expect_t;

    logic         clk;
    logic         reset;
    logic         pxl_cen;
    layer_pixel_t layer;
    blank_t       pre_blank;
    cpu_wr_t      cpu;
    cpu_word_t    cpu_din;
    rgb_t         rgb;
    blank_t       blank;

    // palette mirror and pipeline model
    logic [`PAL_DW-1:0] mirror [1 << `PAL_AW];
    logic [13:0]        held_obj;
    expect_t            exp_q [$];
    logic [31:0]        lcg_state;
    int                 strobe_count;
    int                 test_errors;
    int                 error_total;
    int                 check_total;
    int                 tests_run;
    int                 tests_failed;
    event               abort_ev;

    colmix_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .pxl_cen   (pxl_cen),
        .layer     (layer),
        .pre_blank (pre_blank),
        .cpu       (cpu),
        .cpu_din   (cpu_din),
        .rgb       (rgb),
        .blank     (blank)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // strobes as the DUT sees them
    always @(posedge clk) begin
        if (pxl_cen) begin
            strobe_count <= strobe_count + 1;
        end
    end

    // a timed-out wait ends the run here
    initial begin
        @(abort_ev);
        $display("Some tests failed");
        $finish;
    end

    // lcg step returning the upper bits
    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic layer_pixel_t rand_layer();
        logic [47:0] bits;
        bits = {rand16(), rand16(), rand16()};
        return bits[$bits(layer_pixel_t)-1:0];
    endfunction

    // winning layer and its palette address
    function automatic logic [`PAL_AW-1:0] expected_addr(layer_pixel_t p, logic [13:0] obj);
        logic see_through;
        logic road_free;
        logic road_code;
        see_through = (obj[3:0] == 4'h0) || p.shadow;
        road_free   = (p.rc[3] == 1'b0) || (p.sa == 1'b0 && p.sb == 1'b0);
        road_code   = (obj[11:10] == 2'b10) && (obj[3:0] == 4'b0101);
        if (!p.fix && ((see_through && road_free) || road_code)) begin
            return {2'b01, p.road[7], p.road[7], p.road[7], p.road[6:0]};
        end
        if (p.sa || p.sb || p.fix) begin
            return {1'b0, p.tile_addr};
        end
        return {1'b1, p.obj[13:7], p.obj[3:0]};
    endfunction

    // nibble plus low bit from 12..14
    function automatic rgb_t unpack_word(logic [`PAL_DW-1:0] w);
        rgb_t c;
        c.red   = {w[3:0], w[12]};
        c.green = {w[7:4], w[13]};
        c.blue  = {w[11:8], w[14]};
        return c;
    endfunction

    function automatic logic [`CH_W-1:0] shade_chan(logic [`CH_W-1:0] c, logic bright,
                                                    logic shadow);
        int v;
        if (!shadow) begin
            v = int'(c);
        end else if (bright) begin
            // a quarter brighter and clipped at full scale
            v = int'(c) + int'(c) / 4;
            if (v > 31) begin
                v = 31;
            end
        end else begin
            v = int'(c) - int'(c) / 4;
        end
        return v[`CH_W-1:0];
    endfunction

    function automatic expect_t predict(layer_pixel_t p, blank_t pb);
        expect_t            e;
        logic [`PAL_DW-1:0] w;
        rgb_t               c;
        w = mirror[expected_addr(p, held_obj)];
        c = unpack_word(w);
        e.strobe    = 32'(strobe_count + 1);
        e.rgb.red   = shade_chan(c.red, w[15], p.shadow);
        e.rgb.green = shade_chan(c.green, w[15], p.shadow);
        e.rgb.blue  = shade_chan(c.blue, w[15], p.shadow);
        // either flag low means black
        if (!pb.lhbl || !pb.lvbl) begin
            e.rgb = '0;
        end
        e.blank = pb;
        return e;
    endfunction

    task automatic check_word(input string name, input cpu_word_t got, input cpu_word_t exp);
        check_total++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        check_total++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_blank(input string name, input blank_t got, input blank_t exp);
        check_total++;
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic wait_clocks(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_strobe(input int target);
        int n;
        n = 0;
        while (strobe_count != target && n < STROBE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (strobe_count != target) begin
            $display("timeout: pixel strobe %0d not seen within %0d clocks", target, n);
            -> abort_ev;
            @(negedge clk);
        end
    endtask

    // one pixel strobe, a compare of the pixel two strobes back and an idle clock
    task automatic send_pixel(input layer_pixel_t p, input blank_t pb);
        expect_t e;
        e = predict(p, pb);
        held_obj  = p.obj;
        layer     = p;
        pre_blank = pb;
        pxl_cen   = 1'b1;
        wait_strobe(e.strobe);
        pxl_cen = 1'b0;
        exp_q.push_back(e);
        if (exp_q.size() == 3) begin
            e = exp_q.pop_front();
            check_rgb($sformatf("rgb pixel %0d", e.strobe), rgb, e.rgb);
            check_blank($sformatf("blank pixel %0d", e.strobe), blank, e.blank);
        end
        wait_clocks(1);
    endtask

    // push the last real pixels out
    task automatic flush_pipeline();
        send_pixel('0, 2'b11);
        send_pixel('0, 2'b11);
    endtask

    task automatic cpu_write(input logic [11:0] a, input logic [15:0] d, input logic [1:0] ds);
        cpu.cs   = 1'b1;
        cpu.addr = a;
        cpu.data = d;
        cpu.dswn = ds;
        // byte merge into the mirror
        if (!ds[0]) begin
            mirror[a][7:0] = d[7:0];
        end
        if (!ds[1]) begin
            mirror[a][15:8] = d[15:8];
        end
        wait_clocks(1);
        cpu.cs = 1'b0;
    endtask

    task automatic cpu_read_check(input logic [11:0] a);
        cpu.cs   = 1'b0;
        cpu.addr = a;
        wait_clocks(1);
        check_word("cpu_din", cpu_din, mirror[a]);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        error_total += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        layer_pixel_t p;
        logic [15:0]  r;
        lcg_state    = 32'd84057;
        strobe_count = 0;
        test_errors  = 0;
        error_total  = 0;
        check_total  = 0;
        tests_run    = 0;
        tests_failed = 0;
        held_obj     = '0;
        reset        = 1'b1;
        pxl_cen      = 1'b0;
        layer        = '0;
        pre_blank    = '0;
        cpu          = '0;
        wait_clocks(8);
        reset = 1'b0;

        // outputs idle and black out of reset
        check_rgb("rgb", rgb, '0);
        check_blank("blank", blank, '0);
        // blanked pixels over the unwritten palette stay black
        for (int i = 0; i < 4; i++) begin
            send_pixel('0, 2'b00);
        end
        finish_test("reset_state");

        // full palette fill followed by partial byte writes with read-back
        for (int i = 0; i < (1 << `PAL_AW); i++) begin
            cpu_write(i[11:0], rand16(), 2'b00);
        end
        for (int i = 0; i < 200; i++) begin
            r = rand16();
            cpu_write(r[11:0], rand16(), r[13:12]);
            cpu_read_check(r[11:0]);
        end
        finish_test("cpu_rw");

        // road through a clear object
        for (int i = 0; i < 64; i++) begin
            p          = rand_layer();
            p.fix      = 1'b0;
            p.obj[3:0] = 4'h0;
            p.rc[3]    = 1'b0;
            p.shadow   = 1'b0;
            send_pixel(p, 2'b11);
        end
        flush_pipeline();
        finish_test("road");

        // solid object with random tile flags
        for (int i = 0; i < 96; i++) begin
            p        = rand_layer();
            p.shadow = 1'b0;
            if (p.obj[3:0] == 4'h0) begin
                p.obj[3:0] = 4'h7;
            end
            send_pixel(p, 2'b11);
        end
        flush_pipeline();
        finish_test("tile_object");

        // dim or brighten on every channel
        for (int i = 0; i < 96; i++) begin
            p        = rand_layer();
            p.shadow = 1'b1;
            send_pixel(p, 2'b11);
        end
        flush_pipeline();
        finish_test("shadow");

        for (int i = 0; i < 96; i++) begin
            r = rand16();
            send_pixel(rand_layer(), r[1:0]);
        end
        flush_pipeline();
        finish_test("blanking");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_total, error_total);
        if (error_total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: video_output.sv
`timescale 1ns/1ps
`include "colmix_macros.svh"

module video_output
    import video_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             pxl_cen,
    input  logic [`CH_W-1:0] chan_r,
    input  logic [`CH_W-1:0] chan_g,
    input  logic [`CH_W-1:0] chan_b,
    input  blank_t           pre_blank,
    output rgb_t             rgb,
    output blank_t           blank
);

    rgb_t   colour;
    blank_t blank_dly;
    logic   blanking;

    // blank flags catch up with the colour pipeline
    pixel_delay #(
        .payload_t (blank_t),
        .DEPTH     (`BLANK_DLY)
    ) blank_dly_i (
        .clk     (clk),
        .reset   (reset),
        .pxl_cen (pxl_cen),
        .din     (pre_blank),
        .dout    (blank_dly)
    );

    // pack the channels
    assign colour.red   = chan_r;
    assign colour.green = chan_g;
    assign colour.blue  = chan_b;

    // either flag low blanks the pixel
    assign blanking = !blank_dly.lhbl || !blank_dly.lvbl;

    // final register, colour and flags leave together
    always_ff @(posedge clk) begin
        if (reset) begin
            rgb   <= '0;
            blank <= '0;
        end else if (pxl_cen) begin
            rgb   <= blanking ? rgb_t'('0) : colour;
            blank <= blank_dly;
        end
    end

endmodule

// File: video_pkg.sv
`include "colmix_macros.svh"

package video_pkg;

    // raw inputs from the tile, object and road generators
    typedef struct packed {
        // tile map palette index
        logic [10:0] tile_addr;
        // object pixel, colour in bits 3:0
        logic [13:0] obj;
        // road pixel
        logic [7:0]  road;
        // road control, only bit 3 matters here
        logic [4:3]  rc;
        logic        shadow;
        logic        sa;
        logic        sb;
        // fix layer on top
        logic        fix;
    } layer_pixel_t;

    // travels with each palette lookup
    typedef struct packed {
        logic shadow;
    } shade_ctrl_t;

    // final colour
    typedef struct packed {
        logic [`CH_W-1:0] red;
        logic [`CH_W-1:0] green;
        logic [`CH_W-1:0] blue;
    } rgb_t;

    // blanking, both active low
    typedef struct packed {
        logic lhbl;
        logic lvbl;
    } blank_t;

endpackage
